// File: logic/rs_pkg.sv
`default_nettype none

// Shared types and constants for the reservation station slice
package rs_pkg;

    // ======================================================================
    // Producer tags and CDB layout
    // ======================================================================

    // Tags 0 to 2 name a CDB producer
    typedef logic [1:0] tag_t;

    // Operand value already present, no producer to wait for
    localparam tag_t TAG_READY = 2'd3;

    // One channel per producing unit, channel i carries tag i
    localparam int NUM_CDB = 3;

    // Default widths, the top level passes them down
    localparam int DEFAULT_DATA_WIDTH = 32;
    localparam int DEFAULT_PREG_WIDTH = 6;

    // ======================================================================
    // Opcodes and entry state
    // ======================================================================

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5,
        OP_SRL = 3'd6,
        OP_SLT = 3'd7
    } alu_op_e;

    // Single entry, either free or holding an instruction with a missing operand
    typedef enum logic {
        RS_EMPTY   = 1'b0,
        RS_WAITING = 1'b1
    } rs_state_e;

endpackage

`default_nettype wire

// File: logic/operand_wakeup.sv
`default_nettype none

module operand_wakeup
    import rs_pkg::*;
#(
    parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH
) (
    input  tag_t                               stored_tag,
    input  logic [DATA_WIDTH-1:0]              stored_data,
    input  logic [NUM_CDB-1:0]                 cdb_valid,
    input  logic [NUM_CDB-1:0][DATA_WIDTH-1:0] cdb_data,
    output logic                               present,
    output logic [DATA_WIDTH-1:0]              value
);

    // ======================================================================
    // CDB tag match
    // ======================================================================

    // At most one bit set, each channel owns exactly one tag
    logic [NUM_CDB-1:0]    hit;
    logic [DATA_WIDTH-1:0] cdb_value;

    always_comb begin
        hit = '0;
        cdb_value = '0;
        for (int i = 0; i < NUM_CDB; i++) begin
            // Channel i only wakes an operand waiting on tag i
            if (stored_tag == tag_t'(i) && cdb_valid[i]) begin
                hit[i] = 1'b1;
                cdb_value = cdb_data[i];
            end
        end
    end

    // Present when already captured or broadcast in this very cycle
    assign present = (stored_tag == TAG_READY) || (|hit);

    // Stored word wins once the tag has been rewritten to ready
    assign value = (stored_tag == TAG_READY) ? stored_data : cdb_value;

endmodule

`default_nettype wire

// File: logic/rs_entry.sv
`default_nettype none

module rs_entry
    import rs_pkg::*;
#(
    parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH,
    parameter int PREG_WIDTH = DEFAULT_PREG_WIDTH
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               dispatch_valid,
    output logic                               dispatch_ready,
    input  alu_op_e                            dispatch_op,
    input  logic [PREG_WIDTH-1:0]              dispatch_dest,
    input  tag_t                               src_a_tag,
    input  logic [DATA_WIDTH-1:0]              src_a_data,
    input  tag_t                               src_b_tag,
    input  logic [DATA_WIDTH-1:0]              src_b_data,
    input  logic [NUM_CDB-1:0]                 cdb_valid,
    input  logic [NUM_CDB-1:0][DATA_WIDTH-1:0] cdb_data,
    input  logic                               issue_taken,
    output logic                               issue_valid,
    output alu_op_e                            issue_op,
    output logic [DATA_WIDTH-1:0]              issue_a,
    output logic [DATA_WIDTH-1:0]              issue_b,
    output logic [PREG_WIDTH-1:0]              issue_dest
);

    // ======================================================================
    // Entry storage and wakeup
    // ======================================================================

    rs_state_e             state;
    alu_op_e               st_op;
    logic [PREG_WIDTH-1:0] st_dest;
    tag_t                  st_a_tag;
    tag_t                  st_b_tag;
    logic [DATA_WIDTH-1:0] st_a_data;
    logic [DATA_WIDTH-1:0] st_b_data;

    logic                  a_present;
    logic                  b_present;
    logic [DATA_WIDTH-1:0] a_value;
    logic [DATA_WIDTH-1:0] b_value;

    logic issue_free;
    logic dispatch_fire;
    logic direct_issue;
    logic park;
    logic wake_issue;

    // Wakeup only looks at stored tags, so a broadcast in the dispatch cycle is missed
    operand_wakeup #(.DATA_WIDTH(DATA_WIDTH)) u_wakeup_a (
        .stored_tag  (st_a_tag),
        .stored_data (st_a_data),
        .cdb_valid   (cdb_valid),
        .cdb_data    (cdb_data),
        .present     (a_present),
        .value       (a_value)
    );

    operand_wakeup #(.DATA_WIDTH(DATA_WIDTH)) u_wakeup_b (
        .stored_tag  (st_b_tag),
        .stored_data (st_b_data),
        .cdb_valid   (cdb_valid),
        .cdb_data    (cdb_data),
        .present     (b_present),
        .value       (b_value)
    );

    // Issue register is free when empty or drained this cycle
    assign issue_free     = !issue_valid || issue_taken;
    assign dispatch_ready = (state == RS_EMPTY) && issue_free;
    assign dispatch_fire  = dispatch_valid && dispatch_ready;

    // Both sources present at dispatch bypass the entry
    assign direct_issue = dispatch_fire && (src_a_tag == TAG_READY) && (src_b_tag == TAG_READY);
    assign park         = dispatch_fire && !direct_issue;

    // Last missing operand arriving on the CDB issues in the same cycle
    assign wake_issue = (state == RS_WAITING) && a_present && b_present && issue_free;

    // Control part, tags are rewritten to ready once captured
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= RS_EMPTY;
            st_a_tag <= TAG_READY;
            st_b_tag <= TAG_READY;
        end else if (park) begin
            state <= RS_WAITING;
            st_a_tag <= src_a_tag;
            st_b_tag <= src_b_tag;
        end else if (state == RS_WAITING) begin
            if (a_present) begin
                st_a_tag <= TAG_READY;
            end
            if (b_present) begin
                st_b_tag <= TAG_READY;
            end
            if (wake_issue) begin
                state <= RS_EMPTY;
            end
        end
    end

    // Payload, captured values survive a blocked issue stage
    always_ff @(posedge clk) begin
        if (park) begin
            st_op <= dispatch_op;
            st_dest <= dispatch_dest;
            st_a_data <= src_a_data;
            st_b_data <= src_b_data;
        end else if (state == RS_WAITING) begin
            if (a_present) begin
                st_a_data <= a_value;
            end
            if (b_present) begin
                st_b_data <= b_value;
            end
        end
    end

    // ======================================================================
    // Issue register
    // ======================================================================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            issue_valid <= 1'b0;
        end else if (direct_issue || wake_issue) begin
            issue_valid <= 1'b1;
        end else if (issue_taken) begin
            issue_valid <= 1'b0;
        end
    end

    // Holds its contents under back-pressure, loads never overlap
    always_ff @(posedge clk) begin
        if (direct_issue) begin
            issue_op <= dispatch_op;
            issue_a <= src_a_data;
            issue_b <= src_b_data;
            issue_dest <= dispatch_dest;
        end else if (wake_issue) begin
            issue_op <= st_op;
            issue_a <= a_value;
            issue_b <= b_value;
            issue_dest <= st_dest;
        end
    end

    // ======================================================================
    // Checks
    // ======================================================================

    // Waiting instruction is never overwritten by a new dispatch
    a_waiting_holds_entry: assert property (@(posedge clk) disable iff (!reset)
        (state == RS_WAITING) |=> $stable(st_op) && $stable(st_dest))
        else $error("rs_entry: dispatch accepted while waiting");

    // ALU back-pressure freezes the issue stage
    a_issue_stable: assert property (@(posedge clk) disable iff (!reset)
        issue_valid && !issue_taken |=> issue_valid && $stable(issue_op) &&
            $stable(issue_a) && $stable(issue_b) && $stable(issue_dest))
        else $error("rs_entry: issue outputs changed under back-pressure");

endmodule

`default_nettype wire

// File: logic/alu_unit.sv
`default_nettype none

module alu_unit
    import rs_pkg::*;
#(
    parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH,
    parameter int PREG_WIDTH = DEFAULT_PREG_WIDTH
) (
    input  logic                  issue_valid,
    input  alu_op_e               issue_op,
    input  logic [DATA_WIDTH-1:0] issue_a,
    input  logic [DATA_WIDTH-1:0] issue_b,
    input  logic [PREG_WIDTH-1:0] issue_dest,
    output logic                  issue_taken,
    output logic                  result_valid,
    output logic [DATA_WIDTH-1:0] result_data,
    output logic [PREG_WIDTH-1:0] result_dest,
    input  logic                  result_ready
);

    // ======================================================================
    // Datapath
    // ======================================================================

    // Shift amount from the low five bits of b
    logic [4:0]            shamt;
    logic                  less;
    logic [DATA_WIDTH-1:0] alu_out;

    assign shamt = issue_b[4:0];
    assign less  = $signed(issue_a) < $signed(issue_b);

    always_comb begin
        case (issue_op)
            OP_ADD: alu_out = issue_a + issue_b;
            OP_SUB: alu_out = issue_a - issue_b;
            OP_AND: alu_out = issue_a & issue_b;
            OP_OR:  alu_out = issue_a | issue_b;
            OP_XOR: alu_out = issue_a ^ issue_b;
            OP_SLL: alu_out = issue_a << shamt;
            OP_SRL: alu_out = issue_a >> shamt;
            // Signed compare, zero extended flag
            OP_SLT: alu_out = {{(DATA_WIDTH-1){1'b0}}, less};
            default: alu_out = '0;
        endcase
    end

    // ======================================================================
    // Result handshake
    // ======================================================================

    // Single cycle unit, issue register doubles as the result holding stage
    assign result_valid = issue_valid;
    assign result_data  = alu_out;
    assign result_dest  = issue_dest;

    // Issue stage drains only when the arbiter takes the result
    assign issue_taken = issue_valid && result_ready;

    // ======================================================================
    // Checks
    // ======================================================================

    // Opcode from the entry must be a known value while valid
    always_comb begin
        if (issue_valid) begin
            assert (!$isunknown(issue_op))
                else $error("alu_unit: undefined opcode on valid issue");
        end
    end

endmodule

`default_nettype wire

// File: logic/alu_issue_slice.sv
`default_nettype none

module alu_issue_slice
    import rs_pkg::*;
#(
    parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH,
    parameter int PREG_WIDTH = DEFAULT_PREG_WIDTH
) (
    input  logic                               clk,
    input  logic                               reset,
    // Dispatch group
    input  logic                               dispatch_valid,
    output logic                               dispatch_ready,
    input  alu_op_e                            dispatch_op,
    input  logic [PREG_WIDTH-1:0]              dispatch_dest,
    input  tag_t                               src_a_tag,
    input  logic [DATA_WIDTH-1:0]              src_a_data,
    input  tag_t                               src_b_tag,
    input  logic [DATA_WIDTH-1:0]              src_b_data,
    // CDB snoop
    input  logic [NUM_CDB-1:0]                 cdb_valid,
    input  logic [NUM_CDB-1:0][DATA_WIDTH-1:0] cdb_data,
    // Result toward the CDB arbiter
    output logic                               result_valid,
    output logic [DATA_WIDTH-1:0]              result_data,
    output logic [PREG_WIDTH-1:0]              result_dest,
    input  logic                               result_ready
);

    // ======================================================================
    // Issue stage between entry and ALU
    // ======================================================================

    logic                  issue_valid;
    logic                  issue_taken;
    alu_op_e               issue_op;
    logic [DATA_WIDTH-1:0] issue_a;
    logic [DATA_WIDTH-1:0] issue_b;
    logic [PREG_WIDTH-1:0] issue_dest;

    rs_entry #(
        .DATA_WIDTH (DATA_WIDTH),
        .PREG_WIDTH (PREG_WIDTH)
    ) u_rs_entry (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_op    (dispatch_op),
        .dispatch_dest  (dispatch_dest),
        .src_a_tag      (src_a_tag),
        .src_a_data     (src_a_data),
        .src_b_tag      (src_b_tag),
        .src_b_data     (src_b_data),
        .cdb_valid      (cdb_valid),
        .cdb_data       (cdb_data),
        .issue_taken    (issue_taken),
        .issue_valid    (issue_valid),
        .issue_op       (issue_op),
        .issue_a        (issue_a),
        .issue_b        (issue_b),
        .issue_dest     (issue_dest)
    );

    // ALU result leaves on its own port, CDB merging happens outside
    alu_unit #(
        .DATA_WIDTH (DATA_WIDTH),
        .PREG_WIDTH (PREG_WIDTH)
    ) u_alu_unit (
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_a      (issue_a),
        .issue_b      (issue_b),
        .issue_dest   (issue_dest),
        .issue_taken  (issue_taken),
        .result_valid (result_valid),
        .result_data  (result_data),
        .result_dest  (result_dest),
        .result_ready (result_ready)
    );

endmodule

`default_nettype wire

// File: bench/tb_alu_issue_slice.sv
`default_nettype none

module tb_alu_issue_slice
    import rs_pkg::*;
();

    localparam int DATA_WIDTH   = DEFAULT_DATA_WIDTH;
    localparam int PREG_WIDTH   = DEFAULT_PREG_WIDTH;
    localparam int NUM_DISPATCH = 300;
    // Worst case wait per instruction, plus reset and drain
    localparam int MAX_CYCLES   = 40 * NUM_DISPATCH + 100;

    logic                               clk = 1'b0;
    logic                               reset;
    logic                               dispatch_valid;
    logic                               dispatch_ready;
    alu_op_e                            dispatch_op;
    logic [PREG_WIDTH-1:0]              dispatch_dest;
    tag_t                               src_a_tag;
    logic [DATA_WIDTH-1:0]              src_a_data;
    tag_t                               src_b_tag;
    logic [DATA_WIDTH-1:0]              src_b_data;
    logic [NUM_CDB-1:0]                 cdb_valid;
    logic [NUM_CDB-1:0][DATA_WIDTH-1:0] cdb_data;
    logic                               result_valid;
    logic [DATA_WIDTH-1:0]              result_data;
    logic [PREG_WIDTH-1:0]              result_dest;
    logic                               result_ready;

    // ======================================================================
    // Reference model state
    // ======================================================================

    logic [31:0]           lfsr = 32'h0355_bfad;
    int                    errors = 0;
    int                    checks = 0;
    int                    cycles = 0;
    int                    offered = 0;
    int                    sent = 0;
    int                    parked = 0;
    int                    results = 0;
    logic                  last_fire = 1'b0;
    // Copy of the entry
    logic                  m_waiting = 1'b0;
    alu_op_e               m_op;
    logic [PREG_WIDTH-1:0] m_dest;
    tag_t                  m_a_tag;
    tag_t                  m_b_tag;
    logic [DATA_WIDTH-1:0] m_a_data;
    logic [DATA_WIDTH-1:0] m_b_data;
    // Issue stage occupancy and results still owed, oldest first
    logic                  m_iss_full = 1'b0;
    logic [DATA_WIDTH-1:0] exp_data_q[$];
    logic [PREG_WIDTH-1:0] exp_dest_q[$];
    logic [7:0]            op_seen = 8'h00;

    alu_issue_slice #(
        .DATA_WIDTH (DATA_WIDTH),
        .PREG_WIDTH (PREG_WIDTH)
    ) u_alu_issue_slice (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_op    (dispatch_op),
        .dispatch_dest  (dispatch_dest),
        .src_a_tag      (src_a_tag),
        .src_a_data     (src_a_data),
        .src_b_tag      (src_b_tag),
        .src_b_data     (src_b_data),
        .cdb_valid      (cdb_valid),
        .cdb_data       (cdb_data),
        .result_valid   (result_valid),
        .result_data    (result_data),
        .result_dest    (result_dest),
        .result_ready   (result_ready)
    );

    always #50 clk = ~clk;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
        end
        return r;
    endfunction

    // ALU behavior, shifts by the low five bits of b
    function automatic logic [31:0] expected_result(input alu_op_e op, input logic [31:0] a,
                                                    input logic [31:0] b);
        int unsigned sh;
        sh = b & 32'h1F;
        case (op)
            OP_ADD: return a + b;
            OP_SUB: return a - b;
            OP_AND: return a & b;
            OP_OR: return a | b;
            OP_XOR: return a ^ b;
            OP_SLL: return a << sh;
            OP_SRL: return a >> sh;
            OP_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return 32'd0;
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // ======================================================================
    // Stimulus, applied just after the rising edge
    // ======================================================================

    task automatic drive_inputs();
        logic [31:0] r;
        for (int i = 0; i < NUM_CDB; i++) begin
            cdb_valid[i] = (take_bits(2) == 32'd3);
            cdb_data[i] = take_bits(DATA_WIDTH);
        end
        // Arbiter stalls about a quarter of the time
        result_ready = (take_bits(2) != 32'd0);
        if (last_fire) begin
            dispatch_valid = 1'b0;
        end
        // Payload stays put while the offer is pending
        if (!dispatch_valid && offered < NUM_DISPATCH && take_bits(1) == 32'd1) begin
            offered++;
            dispatch_valid = 1'b1;
            r = take_bits(3);
            dispatch_op = alu_op_e'(r[2:0]);
            r = take_bits(PREG_WIDTH);
            dispatch_dest = r[PREG_WIDTH-1:0];
            src_a_data = take_bits(DATA_WIDTH);
            src_b_data = take_bits(DATA_WIDTH);
            src_a_tag = TAG_READY;
            src_b_tag = TAG_READY;
            // Half the offers go straight to issue
            if (take_bits(1) == 32'd0) begin
                r = take_bits(2);
                src_a_tag = r[1:0];
                r = take_bits(2);
                src_b_tag = r[1:0];
            end
        end
    endtask

    // ======================================================================
    // Model step, run at the falling edge for the next rising edge
    // ======================================================================

    task automatic model_step();
        logic iss_free;
        logic model_ready;
        logic taken;
        logic new_iss;
        iss_free = !m_iss_full || result_ready;
        model_ready = !m_waiting && iss_free;
        compare("dispatch_ready", 32'(model_ready), 32'(dispatch_ready));
        compare("result_valid", 32'(m_iss_full), 32'(result_valid));
        taken = m_iss_full && result_ready;
        if (result_valid && result_ready) begin
            if (exp_data_q.size() == 0) begin
                errors++;
                $display("Result for dest %0d taken with nothing outstanding", result_dest);
            end else begin
                compare("result_data", exp_data_q.pop_front(), result_data);
                compare("result_dest", 32'(exp_dest_q.pop_front()), 32'(result_dest));
                results++;
            end
        end
        last_fire = dispatch_valid && model_ready;
        new_iss = 1'b0;
        if (last_fire) begin
            sent++;
            if (src_a_tag == TAG_READY && src_b_tag == TAG_READY) begin
                exp_data_q.push_back(expected_result(dispatch_op, src_a_data, src_b_data));
                exp_dest_q.push_back(dispatch_dest);
                op_seen[dispatch_op] = 1'b1;
                new_iss = 1'b1;
            end else begin
                // CDB in this cycle is not seen by the new entry
                parked++;
                m_waiting = 1'b1;
                m_op = dispatch_op;
                m_dest = dispatch_dest;
                m_a_tag = src_a_tag;
                m_b_tag = src_b_tag;
                m_a_data = src_a_data;
                m_b_data = src_b_data;
            end
        end else if (m_waiting) begin
            if (m_a_tag != TAG_READY && cdb_valid[m_a_tag]) begin
                m_a_data = cdb_data[m_a_tag];
                m_a_tag = TAG_READY;
            end
            if (m_b_tag != TAG_READY && cdb_valid[m_b_tag]) begin
                m_b_data = cdb_data[m_b_tag];
                m_b_tag = TAG_READY;
            end
            // Issues in the cycle the last operand arrives, if the stage is free
            if (m_a_tag == TAG_READY && m_b_tag == TAG_READY && iss_free) begin
                exp_data_q.push_back(expected_result(m_op, m_a_data, m_b_data));
                exp_dest_q.push_back(m_dest);
                m_waiting = 1'b0;
                new_iss = 1'b1;
            end
        end
        m_iss_full = new_iss || (m_iss_full && !taken);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d results out",
                     cycles, results, NUM_DISPATCH);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        reset = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_op = OP_ADD;
        dispatch_dest = '0;
        src_a_tag = TAG_READY;
        src_b_tag = TAG_READY;
        src_a_data = '0;
        src_b_data = '0;
        cdb_valid = '0;
        cdb_data = '0;
        result_ready = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b1;
        @(negedge clk);
        compare("reset_dispatch_ready", 32'd1, 32'(dispatch_ready));
        compare("reset_result_valid", 32'd0, 32'(result_valid));
        while (sent < NUM_DISPATCH || m_waiting || m_iss_full) begin
            @(posedge clk);
            #1;
            drive_inputs();
            @(negedge clk);
            model_step();
        end
        compare("result_count", NUM_DISPATCH, results);
        compare("queue_left", 32'd0, 32'(exp_data_q.size()));
        if (op_seen != 8'hFF) begin
            errors++;
            $display("Not every opcode went through direct issue, mask %b", op_seen);
        end
        if (parked == 0) begin
            errors++;
            $display("No dispatch ever waited on the CDB");
        end
        $display("Dispatched %0d, parked %0d, results %0d, checks %0d, errors %0d",
                 sent, parked, results, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: alu_issue_slice.f
logic/rs_pkg.sv
logic/operand_wakeup.sv
logic/rs_entry.sv
logic/alu_unit.sv
logic/alu_issue_slice.sv
bench/tb_alu_issue_slice.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the alu_issue_slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f alu_issue_slice.f \
    --top-module tb_alu_issue_slice -Mdir "$build_dir" -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/sim_tb" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "NO ERRORS" "$log_file"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see $log_file"
exit 1
